// ==== Makefile ====
# every source named in the file list, so an edit rebuilds the binary
SRCS := $(shell grep -v '^+' bp_top.f)

.PHONY: all run clean

all: run

obj_dir/bp_tb: bp_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module bp_tb -f bp_top.f -o bp_tb

# pass only when the simulation prints the pass line
run: obj_dir/bp_tb
	@out=$$(./obj_dir/bp_tb); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== bench/bp_assert.sv ====
`timescale 1ns/1ps

module bp_assert
   import bp_pkg::*;
#(
   parameter int FETCHW = 4
) (
   input logic                      clk,
   input logic                      rst_n,
   input logic [PC_W-1:0]           pc_i,
   input logic [PC_W-1:0]           next_pc_o,
   input logic                      taken_o,
   input logic [$clog2(FETCHW)-1:0] taken_slot_o
);

   // bytes per fetch group
   localparam int GRP = FETCHW * 4;

   // one failure count per property
   int fails_seq = 0;
   int fails_slot = 0;
   int fails_x = 0;
   // total, read by the testbench
   int fails;

   // start of the following group
   logic [PC_W-1:0] seq_pc;

   assign seq_pc = pc_i - (pc_i % PC_W'(GRP)) + PC_W'(GRP);
   assign fails  = fails_seq + fails_slot + fails_x;

   // no redirect means fall through to the next group
   a_seq: assert property (@(posedge clk) disable iff (!rst_n)
      !taken_o |-> next_pc_o == seq_pc)
      else begin
         fails_seq++;
         $error("next_pc_o is not the next group base without a redirect");
      end

   // slot index parked at zero
   a_slot: assert property (@(posedge clk) disable iff (!rst_n)
      !taken_o |-> taken_slot_o == '0)
      else begin
         fails_slot++;
         $error("taken_slot_o is nonzero without a redirect");
      end

   // outputs fully known once out of reset
   a_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown({next_pc_o, taken_o, taken_slot_o}))
      else begin
         fails_x++;
         $error("predictor output is unknown");
      end

endmodule

bind bp_top bp_assert #(
   .FETCHW (FETCHW)
) u_assert (
   .clk          (clk),
   .rst_n        (rst_n),
   .pc_i         (pc_i),
   .next_pc_o    (next_pc_o),
   .taken_o      (taken_o),
   .taken_slot_o (taken_slot_o)
);

// ==== bench/bp_checker.sv ====
`timescale 1ns/1ps

module bp_checker
   import bp_pkg::*;
#(
   parameter int BTBW   = 6,
   parameter int FETCHW = 4
) (
   input  logic                      clk,
   input  logic                      rst_n,
   // compare this cycle
   input  logic                      chk_en_i,
   // table expectations are valid
   input  logic                      tbl_en_i,
   // end of stimulus, print the summary
   input  logic                      done_i,
   input  logic [95:0]               name_i,
   input  logic [PC_W-1:0]           pc_i,
   input  bp_update_t                upd_i,
   input  logic [PC_W-1:0]           exp_next_i,
   input  logic                      exp_taken_i,
   // DUT outputs
   input  logic [PC_W-1:0]           next_pc_i,
   input  logic                      taken_i,
   input  logic [$clog2(FETCHW)-1:0] taken_slot_i,
   // failures seen by the bound assertions
   input  int                        assert_fails_i,
   output int                        errors_o
);

   localparam int DEPTH = 1 << BTBW;
   localparam int GRP   = FETCHW * 4;

   // model of every bank, counters kept as plain integers 0..3
   int              ctr_m [FETCHW][DEPTH];
   logic [PC_W-1:0] tgt_m [FETCHW][DEPTH];

   int              err_cnt = 0;
   int              checks = 0;

   // model answer for the current fetch PC
   logic [PC_W-1:0] m_next;
   logic            m_taken;
   int              m_slot;

   assign errors_o = err_cnt + assert_fails_i;

   task automatic compare_value(input string what, input logic [PC_W-1:0] exp,
                                input logic [PC_W-1:0] act);
      checks++;
      if (exp !== act) begin
         err_cnt++;
         $display("Fail %s %s: expected %h, actual %h", name_i, what, exp, act);
      end
   endtask

   // first valid slot whose counter says taken
   task automatic predict(input logic [PC_W-1:0] pc);
      int word;
      int idx;
      logic [PC_W-1:0] base;
      base    = pc - (pc % PC_W'(GRP));
      word    = int'((pc / 4) % FETCHW);
      idx     = int'((pc / GRP) % DEPTH);
      m_next  = base + PC_W'(GRP);
      m_taken = 1'b0;
      m_slot  = 0;
      for (int k = 0; k < FETCHW; k++) begin
         if (!m_taken && k >= word && ctr_m[k][idx] >= 2) begin
            m_taken = 1'b1;
            m_next  = tgt_m[k][idx];
            m_slot  = k;
         end
      end
   endtask

   // resolved branch, bank from word offset, entry from bits above the group
   task automatic learn(input bp_update_t u);
      int bank;
      int idx;
      bank = int'((u.pc / 4) % FETCHW);
      idx  = int'((u.pc / GRP) % DEPTH);
      if (u.taken) begin
         if (ctr_m[bank][idx] < 3) begin
            ctr_m[bank][idx]++;
         end
         tgt_m[bank][idx] = u.target;
      end else if (ctr_m[bank][idx] > 0) begin
         ctr_m[bank][idx]--;
      end
   endtask

   // outputs read before this edge's write lands
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int k = 0; k < FETCHW; k++) begin
            for (int e = 0; e < DEPTH; e++) begin
               ctr_m[k][e] = 0;
               tgt_m[k][e] = '0;
            end
         end
      end else begin
         if (chk_en_i) begin
            predict(pc_i);
            compare_value("next_pc", m_next, next_pc_i);
            compare_value("taken", PC_W'(m_taken), PC_W'(taken_i));
            compare_value("slot", PC_W'(m_slot), PC_W'(taken_slot_i));
            if (tbl_en_i) begin
               compare_value("table next_pc", exp_next_i, next_pc_i);
               compare_value("table taken", PC_W'(exp_taken_i), PC_W'(taken_i));
            end
         end
         if (upd_i.valid) begin
            learn(upd_i);
         end
      end
   end

   always @(posedge done_i) begin
      $display("checks: %0d, value errors: %0d, assertion failures: %0d",
               checks, err_cnt, assert_fails_i);
   end

endmodule

// ==== bench/bp_tb.sv ====
`timescale 1ns/1ps

module bp_tb
   import bp_pkg::*;
#(
   parameter int BTBW   = 6,
   parameter int FETCHW = 4
);

   localparam int PERIOD  = 4;
   localparam int RST_CYC = 3;
   localparam int N_RAND  = 300;
   localparam int MARGIN  = 20;

   // branch addresses for the random phase
   // 0x1400 and 0x9408 alias group 0x1000
   localparam logic [31:0] BR_PC [8] = '{
      32'h1000, 32'h1004, 32'h1008, 32'h100C,
      32'h1400, 32'h2014, 32'h201C, 32'h9408
   };

   // one table step, lookup plus optional update
   typedef struct packed {
      logic [95:0]     name;
      logic [PC_W-1:0] pc;
      bp_update_t      upd;
      logic [PC_W-1:0] exp_next;
      logic            exp_taken;
   } row_t;

   logic                      clk;
   logic                      rst_n;
   logic [PC_W-1:0]           pc;
   bp_update_t                upd;
   logic [PC_W-1:0]           next_pc;
   logic                      taken;
   logic [$clog2(FETCHW)-1:0] taken_slot;

   logic                      chk_en;
   logic                      tbl_en;
   logic                      done;
   logic [95:0]               name;
   logic [PC_W-1:0]           exp_next;
   logic                      exp_taken;
   int                        errors;

   row_t                      rows [$];
   logic                      table_ready;
   logic [31:0]               lcg_state;

   bp_top #(
      .BTBW   (BTBW),
      .FETCHW (FETCHW)
   ) uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .pc_i         (pc),
      .upd_i        (upd),
      .next_pc_o    (next_pc),
      .taken_o      (taken),
      .taken_slot_o (taken_slot)
   );

   bp_checker #(
      .BTBW   (BTBW),
      .FETCHW (FETCHW)
   ) u_chk (
      .clk            (clk),
      .rst_n          (rst_n),
      .chk_en_i       (chk_en),
      .tbl_en_i       (tbl_en),
      .done_i         (done),
      .name_i         (name),
      .pc_i           (pc),
      .upd_i          (upd),
      .exp_next_i     (exp_next),
      .exp_taken_i    (exp_taken),
      .next_pc_i      (next_pc),
      .taken_i        (taken),
      .taken_slot_i   (taken_slot),
      .assert_fails_i (uut.u_assert.fails),
      .errors_o       (errors)
   );

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic add_lookup(input logic [95:0] nm, input logic [PC_W-1:0] fpc,
                             input logic [PC_W-1:0] enext, input logic etk);
      row_t r;
      r = '0;
      r.name      = nm;
      r.pc        = fpc;
      r.exp_next  = enext;
      r.exp_taken = etk;
      rows.push_back(r);
   endtask

   task automatic add_update(input logic [95:0] nm, input logic [PC_W-1:0] fpc,
                             input logic [PC_W-1:0] bpc, input logic btk,
                             input logic [PC_W-1:0] btgt, input logic [PC_W-1:0] enext,
                             input logic etk);
      row_t r;
      r = '0;
      r.name       = nm;
      r.pc         = fpc;
      r.upd.valid  = 1'b1;
      r.upd.pc     = bpc;
      r.upd.taken  = btk;
      r.upd.target = btgt;
      r.exp_next   = enext;
      r.exp_taken  = etk;
      rows.push_back(r);
   endtask

   // expected values hold for the state before the row's own update
   task automatic build_table();
      add_lookup("rst_a",     32'h1000, 32'h1010, 1'b0);
      add_lookup("rst_b",     32'h1238, 32'h1240, 1'b0);
      add_update("train1",    32'h1000, 32'h1004, 1'b1, 32'h2000, 32'h1010, 1'b0);
      add_update("train2",    32'h1000, 32'h1004, 1'b1, 32'h2000, 32'h1010, 1'b0);
      add_lookup("weak_t",    32'h1000, 32'h2000, 1'b1);
      add_update("train3",    32'h1000, 32'h1004, 1'b1, 32'h2000, 32'h2000, 1'b1);
      add_update("train4",    32'h1000, 32'h1004, 1'b1, 32'h2000, 32'h2000, 1'b1);
      // not-taken updates carry a junk target that must not be stored
      add_update("nt1",       32'h1000, 32'h1004, 1'b0, 32'h0bad0000, 32'h2000, 1'b1);
      add_lookup("sat_hold",  32'h1000, 32'h2000, 1'b1);
      add_update("nt2",       32'h1000, 32'h1004, 1'b0, 32'h0bad0000, 32'h2000, 1'b1);
      add_update("nt3",       32'h1000, 32'h1004, 1'b0, 32'h0bad0000, 32'h1010, 1'b0);
      add_lookup("nt_done",   32'h1000, 32'h1010, 1'b0);
      add_update("retrain1",  32'h1000, 32'h1004, 1'b1, 32'h2000, 32'h1010, 1'b0);
      add_update("retrain2",  32'h1000, 32'h1004, 1'b1, 32'h2000, 32'h1010, 1'b0);
      add_lookup("retrained", 32'h1000, 32'h2000, 1'b1);
      // second branch in slot 3 of the same group
      add_update("slot3_a",   32'h1000, 32'h100C, 1'b1, 32'h3000, 32'h2000, 1'b1);
      add_update("slot3_b",   32'h1000, 32'h100C, 1'b1, 32'h3000, 32'h2000, 1'b1);
      add_lookup("prio_base", 32'h1000, 32'h2000, 1'b1);
      add_lookup("prio_off2", 32'h1008, 32'h3000, 1'b1);
      add_lookup("prio_off3", 32'h100C, 32'h3000, 1'b1);
      add_lookup("prio_off1", 32'h1004, 32'h2000, 1'b1);
      // same index bits, different upper PC
      add_lookup("alias_a",   32'h1400, 32'h2000, 1'b1);
      add_lookup("alias_b",   32'h9008, 32'h3000, 1'b1);
      add_lookup("other_grp", 32'h1010, 32'h1020, 1'b0);
   endtask

   task automatic apply_row(input row_t r);
      name      = r.name;
      pc        = r.pc;
      upd       = r.upd;
      exp_next  = r.exp_next;
      exp_taken = r.exp_taken;
   endtask

   // mostly valid, mostly taken, so counters climb and fall
   task automatic drive_random();
      logic [31:0] r;
      r          = next_rand();
      pc         = BR_PC[r[18:16]];
      upd.valid  = (r[20:19] != 2'b00);
      upd.pc     = BR_PC[r[23:21]];
      upd.taken  = (r[25:24] != 2'b00);
      upd.target = {16'h0008, r[31:26], 10'h000};
   endtask

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // bound from the table length, random count and reset
   initial begin
      wait (table_ready);
      #((rows.size() + N_RAND + RST_CYC + MARGIN) * PERIOD);
      $display("timeout: stimulus did not complete in time");
      $display("Errors found");
      $finish;
   end

   initial begin
      rst_n       = 1'b0;
      pc          = '0;
      upd         = '0;
      chk_en      = 1'b0;
      tbl_en      = 1'b0;
      done        = 1'b0;
      name        = '0;
      exp_next    = '0;
      exp_taken   = 1'b0;
      lcg_state   = 32'd31;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (RST_CYC) @(posedge clk);
      @(negedge clk);
      rst_n  = 1'b1;
      chk_en = 1'b1;
      tbl_en = 1'b1;
      foreach (rows[i]) begin
         apply_row(rows[i]);
         @(negedge clk);
      end
      tbl_en = 1'b0;
      name   = "random";
      for (int i = 0; i < N_RAND; i++) begin
         drive_random();
         @(negedge clk);
      end
      chk_en = 1'b0;
      upd    = '0;
      done   = 1'b1;
      #1;
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== bp_top.f ====
source/bp_pkg.sv
source/fetch_slot_split.sv
source/bp_bank.sv
source/fetch_redirect.sv
source/bp_top.sv
bench/bp_assert.sv
bench/bp_checker.sv
bench/bp_tb.sv

// ==== source/bp_bank.sv ====
`timescale 1ns/1ps

module bp_bank
   import bp_pkg::*;
#(
   parameter int BTBW   = 6,
   parameter int FETCHW = 4
) (
   input  logic       clk,
   input  logic       rst_n,
   // lookup request for this slot
   input  bp_slot_t   slot_i,
   // update steered to this bank
   input  bp_update_t upd_i,
   // prediction for this slot
   output bp_pred_t   pred_o
);

   // number of table entries
   localparam int DEPTH = 1 << BTBW;
   // index starts above the whole group offset
   localparam int GRP_B = $clog2(FETCHW) + SLOT_B;

   // direction table
   ctr_t            ctr_q [DEPTH];
   // branch target buffer, untagged
   logic [PC_W-1:0] tgt_q [DEPTH];

   // lookup and update indexes straight from PC bits
   logic [BTBW-1:0] rd_idx;
   logic [BTBW-1:0] upd_idx;

   // counter at the update index, before and after the step
   ctr_t            ctr_cur;
   ctr_t            ctr_nxt;

   assign rd_idx  = slot_i.pc[GRP_B +: BTBW];
   assign upd_idx = upd_i.pc[GRP_B +: BTBW];

   // one step toward the outcome
   // saturates at both ends
   always_comb begin
      ctr_cur = ctr_q[upd_idx];
      case (ctr_cur)
         STRONG_NT: ctr_nxt = upd_i.taken ? WEAK_NT  : STRONG_NT;
         WEAK_NT:   ctr_nxt = upd_i.taken ? WEAK_T   : STRONG_NT;
         WEAK_T:    ctr_nxt = upd_i.taken ? STRONG_T : WEAK_NT;
         default:   ctr_nxt = upd_i.taken ? STRONG_T : WEAK_T;
      endcase
   end

   // counter write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // every branch starts strongly not taken
         for (int e = 0; e < DEPTH; e++) begin
            ctr_q[e] <= STRONG_NT;
         end
      end else if (upd_i.valid) begin
         ctr_q[upd_idx] <= ctr_nxt;
      end
   end

   // target write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int e = 0; e < DEPTH; e++) begin
            tgt_q[e] <= '0;
         end
      end else if (upd_i.valid && upd_i.taken) begin
         // not-taken outcome keeps the old target
         tgt_q[upd_idx] <= upd_i.target;
      end
   end

   // combinational read
   // new contents show up the cycle after the write edge
   always_comb begin
      pred_o.valid  = slot_i.valid;
      // upper counter bit is the direction
      pred_o.taken  = ctr_q[rd_idx][1];
      pred_o.target = tgt_q[rd_idx];
   end

endmodule

// ==== source/bp_pkg.sv ====
package bp_pkg;

   // fetch address width, fixed so the structs below have fixed widths
   localparam int PC_W = 32;

   // byte offset bits of one 4-byte instruction
   localparam int SLOT_B = 2;

   // 2-bit saturating branch counter
   // upper bit set means predict taken
   typedef enum logic [1:0] {
      STRONG_NT = 2'b00,
      WEAK_NT   = 2'b01,
      WEAK_T    = 2'b10,
      STRONG_T  = 2'b11
   } ctr_t;

   // resolved branch coming back from execute
   typedef struct packed {
      // single-cycle update strobe
      logic            valid;
      // PC of the resolved branch
      logic [PC_W-1:0] pc;
      // actual outcome
      logic            taken;
      // actual target, only meaningful when taken
      logic [PC_W-1:0] target;
   } bp_update_t;

   // lookup request for one slot of the fetch group
   typedef struct packed {
      // slot at or after the fetch PC inside its group
      logic            valid;
      // instruction address of this slot
      logic [PC_W-1:0] pc;
   } bp_slot_t;

   // one bank's answer for its slot
   typedef struct packed {
      // follows the slot valid
      logic            valid;
      // counter upper bit
      logic            taken;
      // BTB entry for the slot index
      logic [PC_W-1:0] target;
   } bp_pred_t;

endpackage

// ==== source/bp_top.sv ====
`timescale 1ns/1ps

module bp_top
   import bp_pkg::*;
#(
   // index bits per bank
   parameter int BTBW   = 6,
   // slots per fetch group, power of two
   parameter int FETCHW = 4
) (
   input  logic                      clk,
   input  logic                      rst_n,
   // fetch address
   input  logic [PC_W-1:0]           pc_i,
   // resolved branch, one per cycle at most
   input  bp_update_t                upd_i,
   // predicted next fetch address
   output logic [PC_W-1:0]           next_pc_o,
   // fetch is redirected
   output logic                      taken_o,
   // slot causing the redirect
   output logic [$clog2(FETCHW)-1:0] taken_slot_o
);

   // splitter to banks
   bp_slot_t   slot_w [FETCHW];
   bp_update_t upd_w  [FETCHW];
   // banks to redirect
   bp_pred_t   pred_w [FETCHW];

   // slot PCs, valids and update steering
   fetch_slot_split #(
      .BTBW   (BTBW),
      .FETCHW (FETCHW)
   ) u_split (
      .pc_i   (pc_i),
      .upd_i  (upd_i),
      .slot_o (slot_w),
      .upd_o  (upd_w)
   );

   // one bank per slot position
   for (genvar k = 0; k < FETCHW; k++) begin : g_bank
      bp_bank #(
         .BTBW   (BTBW),
         .FETCHW (FETCHW)
      ) u_bank (
         .clk    (clk),
         .rst_n  (rst_n),
         .slot_i (slot_w[k]),
         .upd_i  (upd_w[k]),
         .pred_o (pred_w[k])
      );
   end

   // first taken slot or the fall-through group
   fetch_redirect #(
      .FETCHW (FETCHW)
   ) u_redirect (
      .pc_i         (pc_i),
      .pred_i       (pred_w),
      .next_pc_o    (next_pc_o),
      .taken_o      (taken_o),
      .taken_slot_o (taken_slot_o)
   );

endmodule

// ==== source/fetch_redirect.sv ====
`timescale 1ns/1ps

module fetch_redirect
   import bp_pkg::*;
#(
   parameter int FETCHW = 4
) (
   // current fetch address
   input  logic [PC_W-1:0]           pc_i,
   // per-slot bank answers
   input  bp_pred_t                  pred_i [FETCHW],
   // address of the next fetch group
   output logic [PC_W-1:0]           next_pc_o,
   // some slot redirects fetch
   output logic                      taken_o,
   // which slot redirects
   output logic [$clog2(FETCHW)-1:0] taken_slot_o
);

   localparam int WORD_W = $clog2(FETCHW);
   localparam int GRP_B  = WORD_W + SLOT_B;

   // start of the current group
   logic [PC_W-1:0] group_base;
   // fall-through address, start of the following group
   logic [PC_W-1:0] seq_pc;
   // a valid taken slot was found further down the scan
   logic            hit;

   assign group_base = {pc_i[PC_W-1:GRP_B], {GRP_B{1'b0}}};
   // FETCHW words of 4 bytes per group
   assign seq_pc     = group_base + (PC_W'(FETCHW) << SLOT_B);

   // lowest-numbered taken slot wins
   // later slots are never reached in program order
   always_comb begin
      hit          = 1'b0;
      next_pc_o    = seq_pc;
      taken_slot_o = '0;
      for (int k = 0; k < FETCHW; k++) begin
         // invalid slots lie before the fetch PC
         if (!hit && pred_i[k].valid && pred_i[k].taken) begin
            hit          = 1'b1;
            next_pc_o    = pred_i[k].target;
            taken_slot_o = WORD_W'(k);
         end
      end
   end

   // redirect flag
   // slot index already held at zero when nothing hits
   assign taken_o = hit;

endmodule

// ==== source/fetch_slot_split.sv ====
`timescale 1ns/1ps

module fetch_slot_split
   import bp_pkg::*;
#(
   parameter int BTBW   = 6,
   parameter int FETCHW = 4
) (
   // current fetch address
   input  logic [PC_W-1:0] pc_i,
   // resolved branch from execute
   input  bp_update_t      upd_i,
   // per-bank lookup requests
   output bp_slot_t        slot_o [FETCHW],
   // per-bank update, only one bank sees valid
   output bp_update_t      upd_o  [FETCHW]
);

   // word offset bits inside a group
   localparam int WORD_W = $clog2(FETCHW);
   // all offset bits of a group, bytes included
   localparam int GRP_B  = WORD_W + SLOT_B;

   // bank index sits right above the group offset
   // it has to fit inside the PC
   if (GRP_B + BTBW > PC_W) begin : g_idx_chk
      $error("bank index bits exceed PC width");
   end

   // fetch address with group offset cleared
   logic [PC_W-1:0]   group_base;
   // slot number the fetch starts at
   logic [WORD_W-1:0] fetch_word;
   // slot number, and so bank, of the resolved branch
   logic [WORD_W-1:0] upd_word;

   assign group_base = {pc_i[PC_W-1:GRP_B], {GRP_B{1'b0}}};
   assign fetch_word = pc_i[GRP_B-1:SLOT_B];
   assign upd_word   = upd_i.pc[GRP_B-1:SLOT_B];

   // slot PCs and valids
   always_comb begin
      for (int k = 0; k < FETCHW; k++) begin
         // base plus 4k, low bits are zero so an or would do as well
         slot_o[k].pc    = group_base + (PC_W'(k) << SLOT_B);
         // slots before the fetch PC were jumped over
         slot_o[k].valid = (WORD_W'(k) >= fetch_word);
      end
   end

   // update steering
   always_comb begin
      for (int k = 0; k < FETCHW; k++) begin
         // payload goes everywhere, banks ignore it without valid
         upd_o[k]       = upd_i;
         // strobe only for the bank holding this word offset
         upd_o[k].valid = upd_i.valid && (upd_word == WORD_W'(k));
      end
   end

endmodule
